// ==== hdl/sim_pkg.sv ====
// shared widths, opcodes and memory map for the RV64I simulation top; imported by every RTL file
package sim_pkg;

  // one architectural word: register, pc and data values
  typedef logic [63:0] xlen_t;

  // raw 32-bit instruction word
  typedef logic [31:0] inst_t;

  // integer register index x0..x31
  typedef logic [4:0] reg_idx_t;

  // doubleword index into the unified RAM
  typedef logic [8:0] ram_idx_t;

  // bit-level write mask, one bit per data bit
  typedef logic [63:0] wmask_t;

  // trap code reported by the halt instruction
  typedef logic [7:0] trap_code_t;

  // free-running cycle and retired-instruction counters
  typedef logic [63:0] count_t;

  // reset pc, also the base address of the RAM
  localparam xlen_t PC_START = 64'h0000_0000_8000_0000;

  // RAM depth in doublewords, 4 KiB in total
  localparam int RAM_WORDS = 512;

  // major opcodes of the supported subset
  localparam logic [6:0] OPCODE_OP     = 7'h33;
  localparam logic [6:0] OPCODE_OP_IMM = 7'h13;
  localparam logic [6:0] OPCODE_LOAD   = 7'h03;
  localparam logic [6:0] OPCODE_STORE  = 7'h23;
  // custom halt, a0 low byte is the exit code
  localparam logic [6:0] OPCODE_TRAP   = 7'h6b;

  // core control state
  typedef enum logic {
    RUN,
    HALT
  } core_state_t;

endpackage

// ==== hdl/reg_file.sv ====
// 32 x 64-bit integer register file of the core, two combinational reads and one clocked write
module reg_file (
  input  logic              clock,
  input  logic              reset,
  input  sim_pkg::reg_idx_t rs1_index,
  input  sim_pkg::reg_idx_t rs2_index,
  output sim_pkg::xlen_t    rs1_data,
  output sim_pkg::xlen_t    rs2_data,
  input  logic              rd_wena,
  input  sim_pkg::reg_idx_t rd_index,
  input  sim_pkg::xlen_t    rd_data
);
  import sim_pkg::*;

  xlen_t regs [32];

  // architectural state, cleared on reset
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else begin
      // x0 is never written so it reads back as zero
      if (rd_wena && (rd_index != '0)) begin
        regs[rd_index] <= rd_data;
      end
    end
  end

  // read ports see the state before this cycle's write
  always_comb begin
    rs1_data = regs[rs1_index];
    rs2_data = regs[rs2_index];
  end

endmodule

// ==== hdl/alu.sv ====
// 64-bit integer ALU for add, sub, and, or and xor; also does load/store address generation
module alu (
  input  sim_pkg::xlen_t op_a,
  input  sim_pkg::xlen_t op_b,
  input  logic [2:0]     funct3,
  input  logic           sub_sel,
  output sim_pkg::xlen_t result
);

  // funct3 encodings follow the OP / OP-IMM major opcodes
  always_comb begin
    case (funct3)
      3'b100: begin
        result = op_a ^ op_b;
      end
      3'b110: begin
        result = op_a | op_b;
      end
      3'b111: begin
        result = op_a & op_b;
      end
      default: begin
        // funct3 000, and anything unsupported, goes to the adder
        if (sub_sel) begin
          result = op_a - op_b;
        end else begin
          result = op_a + op_b;
        end
      end
    endcase
  end

endmodule

// ==== hdl/rv_core.sv ====
// single-cycle RV64I subset core; fetches and accesses the RAM helper and reports each retire
module rv_core (
  input  logic              clock,
  input  logic              reset,
  output logic              inst_ena,
  output sim_pkg::ram_idx_t inst_index,
  input  sim_pkg::xlen_t    inst_rdata,
  output logic              mem_rena,
  output logic              mem_wena,
  output sim_pkg::ram_idx_t mem_index,
  input  sim_pkg::xlen_t    mem_rdata,
  output sim_pkg::xlen_t    mem_wdata,
  output sim_pkg::wmask_t   mem_wmask,
  output logic              wb_valid,
  output sim_pkg::xlen_t    wb_pc,
  output sim_pkg::inst_t    wb_inst,
  output logic              wb_rd_wena,
  output sim_pkg::reg_idx_t wb_rd_index,
  output sim_pkg::xlen_t    wb_rd_data,
  output sim_pkg::xlen_t    trap_value
);
  import sim_pkg::*;

  core_state_t state;
  logic        booted;
  logic        run;
  xlen_t       pc;
  xlen_t       pc_offset;
  inst_t       inst;
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  reg_idx_t    rd_field;
  reg_idx_t    rs1_field;
  reg_idx_t    rs2_field;
  reg_idx_t    rs2_index;
  logic        is_op;
  logic        is_op_imm;
  logic        is_load;
  logic        is_store;
  logic        is_trap;
  xlen_t       imm_i;
  xlen_t       imm_s;
  xlen_t       rs1_data;
  xlen_t       rs2_data;
  xlen_t       alu_b;
  logic [2:0]  alu_funct3;
  logic        alu_sub;
  xlen_t       alu_result;
  xlen_t       mem_offset;

  // core waits one cycle after reset, then runs until the trap retires
  always_ff @(posedge clock) begin
    if (reset) begin
      state  <= HALT;
      booted <= 1'b0;
      pc     <= PC_START;
    end else begin
      booted <= 1'b1;
      if (!booted) begin
        state <= RUN;
      end else if (run && is_trap) begin
        state <= HALT;
      end
      // pc stays on the trap once halted
      if (run && !is_trap) begin
        pc <= pc + 64'd4;
      end
    end
  end

  assign run = (state == RUN);

  // fetch, the upper word of the doubleword holds odd instructions
  assign pc_offset  = pc - PC_START;
  assign inst_ena   = run;
  assign inst_index = pc_offset[11:3];
  assign inst       = pc[2] ? inst_rdata[63:32] : inst_rdata[31:0];

  // decode
  assign opcode    = inst[6:0];
  assign rd_field  = inst[11:7];
  assign funct3    = inst[14:12];
  assign rs1_field = inst[19:15];
  assign rs2_field = inst[24:20];
  assign is_op     = (opcode == OPCODE_OP);
  assign is_op_imm = (opcode == OPCODE_OP_IMM);
  assign is_load   = (opcode == OPCODE_LOAD);
  assign is_store  = (opcode == OPCODE_STORE);
  assign is_trap   = (opcode == OPCODE_TRAP);
  assign imm_i     = {{52{inst[31]}}, inst[31:20]};
  assign imm_s     = {{52{inst[31]}}, inst[31:25], inst[11:7]};

  // trap reads a0 through the second port
  assign rs2_index = is_trap ? reg_idx_t'(10) : rs2_field;

  reg_file i_reg_file (
    .clock     (clock),
    .reset     (reset),
    .rs1_index (rs1_field),
    .rs2_index (rs2_index),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .rd_wena   (wb_rd_wena),
    .rd_index  (rd_field),
    .rd_data   (wb_rd_data)
  );

  // loads and stores use the adder for the effective address
  assign alu_b      = is_op ? rs2_data : (is_store ? imm_s : imm_i);
  assign alu_funct3 = (is_op || is_op_imm) ? funct3 : 3'b000;
  assign alu_sub    = is_op && inst[30];

  alu i_alu (
    .op_a    (rs1_data),
    .op_b    (alu_b),
    .funct3  (alu_funct3),
    .sub_sel (alu_sub),
    .result  (alu_result)
  );

  // data memory, doubleword aligned only
  assign mem_offset = alu_result - PC_START;
  assign mem_index  = mem_offset[11:3];
  assign mem_rena   = run && is_load;
  assign mem_wena   = run && is_store;
  assign mem_wdata  = rs2_data;
  assign mem_wmask  = '1;

  // writeback and retire report
  assign wb_valid    = run;
  assign wb_pc       = pc;
  assign wb_inst     = inst;
  assign wb_rd_wena  = run && (is_op || is_op_imm || is_load);
  assign wb_rd_index = rd_field;
  assign wb_rd_data  = is_load ? mem_rdata : alu_result;
  assign trap_value  = rs2_data;

endmodule

// ==== hdl/ram_helper.sv ====
// unified instruction/data RAM with combinational reads, a masked write port and a preload port
module ram_helper (
  input  logic              clock,
  input  logic              inst_ena,
  input  sim_pkg::ram_idx_t inst_index,
  output sim_pkg::xlen_t    inst_rdata,
  input  logic              data_ena,
  input  sim_pkg::ram_idx_t data_index,
  output sim_pkg::xlen_t    data_rdata,
  input  logic              wena,
  input  sim_pkg::ram_idx_t windex,
  input  sim_pkg::xlen_t    wdata,
  input  sim_pkg::wmask_t   wmask,
  input  logic              load_ena,
  input  sim_pkg::ram_idx_t load_index,
  input  sim_pkg::xlen_t    load_data
);
  import sim_pkg::*;

  xlen_t ram [RAM_WORDS];
  xlen_t merged;

  // masked bits come from the store, the rest keep the old word
  assign merged = (ram[windex] & ~wmask) | (wdata & wmask);

  // preload wins if both ports hit in the same cycle
  always_ff @(posedge clock) begin
    if (load_ena) begin
      ram[load_index] <= load_data;
    end else if (wena) begin
      ram[windex] <= merged;
    end
  end

  // disabled read ports return zero
  always_comb begin
    if (inst_ena) begin
      inst_rdata = ram[inst_index];
    end else begin
      inst_rdata = '0;
    end
    if (data_ena) begin
      data_rdata = ram[data_index];
    end else begin
      data_rdata = '0;
    end
  end

endmodule

// ==== hdl/commit_tracker.sv ====
// registers the core's retire into the commit and trap record and keeps the cycle counters
module commit_tracker (
  input  logic                clock,
  input  logic                reset,
  input  logic                wb_valid,
  input  sim_pkg::xlen_t      wb_pc,
  input  sim_pkg::inst_t      wb_inst,
  input  logic                wb_rd_wena,
  input  sim_pkg::reg_idx_t   wb_rd_index,
  input  sim_pkg::xlen_t      wb_rd_data,
  input  sim_pkg::xlen_t      trap_value,
  output logic                commit_valid,
  output logic                commit_skip,
  output logic                commit_wen,
  output sim_pkg::xlen_t      commit_pc,
  output sim_pkg::inst_t      commit_inst,
  output sim_pkg::reg_idx_t   commit_wdest,
  output sim_pkg::xlen_t      commit_wdata,
  output logic                trap_valid,
  output sim_pkg::trap_code_t trap_code,
  output sim_pkg::count_t     cycle_count,
  output sim_pkg::count_t     instr_count
);
  import sim_pkg::*;

  logic retire;

  // a zero pc never counts as a real commit
  assign retire = wb_valid && (wb_pc != '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      commit_valid <= 1'b0;
      commit_skip  <= 1'b0;
      commit_wen   <= 1'b0;
      trap_valid   <= 1'b0;
      cycle_count  <= '0;
      instr_count  <= '0;
    end else begin
      commit_valid <= retire;
      // checker skips the very first instruction
      commit_skip  <= retire && (wb_pc == PC_START);
      commit_wen   <= retire && wb_rd_wena;
      trap_valid   <= retire && (wb_inst[6:0] == OPCODE_TRAP);
      cycle_count  <= cycle_count + count_t'(1);
      instr_count  <= instr_count + count_t'(retire);
    end
  end

  // record payload
  always_ff @(posedge clock) begin
    commit_pc    <= wb_pc;
    commit_inst  <= wb_inst;
    commit_wdest <= wb_rd_index;
    commit_wdata <= wb_rd_data;
    trap_code    <= trap_value[7:0];
  end

endmodule

// ==== hdl/sim_top.sv ====
// simulation top: core and RAM side by side, commit tracker on the retire stream; preloaded in reset
module sim_top (
  input  logic                clock,
  input  logic                reset,
  input  logic                load_ena,
  input  sim_pkg::ram_idx_t   load_index,
  input  sim_pkg::xlen_t      load_data,
  output logic                commit_valid,
  output logic                commit_skip,
  output logic                commit_wen,
  output sim_pkg::xlen_t      commit_pc,
  output sim_pkg::inst_t      commit_inst,
  output sim_pkg::reg_idx_t   commit_wdest,
  output sim_pkg::xlen_t      commit_wdata,
  output logic                trap_valid,
  output sim_pkg::trap_code_t trap_code,
  output sim_pkg::count_t     cycle_count,
  output sim_pkg::count_t     instr_count
);
  import sim_pkg::*;

  logic     inst_ena;
  ram_idx_t inst_index;
  xlen_t    inst_rdata;
  logic     mem_rena;
  logic     mem_wena;
  ram_idx_t mem_index;
  xlen_t    mem_rdata;
  xlen_t    mem_wdata;
  wmask_t   mem_wmask;
  logic     wb_valid;
  xlen_t    wb_pc;
  inst_t    wb_inst;
  logic     wb_rd_wena;
  reg_idx_t wb_rd_index;
  xlen_t    wb_rd_data;
  xlen_t    trap_value;

  rv_core i_core (
    .clock       (clock),
    .reset       (reset),
    .inst_ena    (inst_ena),
    .inst_index  (inst_index),
    .inst_rdata  (inst_rdata),
    .mem_rena    (mem_rena),
    .mem_wena    (mem_wena),
    .mem_index   (mem_index),
    .mem_rdata   (mem_rdata),
    .mem_wdata   (mem_wdata),
    .mem_wmask   (mem_wmask),
    .wb_valid    (wb_valid),
    .wb_pc       (wb_pc),
    .wb_inst     (wb_inst),
    .wb_rd_wena  (wb_rd_wena),
    .wb_rd_index (wb_rd_index),
    .wb_rd_data  (wb_rd_data),
    .trap_value  (trap_value)
  );

  // data read and write share one index from the core
  ram_helper i_ram (
    .clock      (clock),
    .inst_ena   (inst_ena),
    .inst_index (inst_index),
    .inst_rdata (inst_rdata),
    .data_ena   (mem_rena),
    .data_index (mem_index),
    .data_rdata (mem_rdata),
    .wena       (mem_wena),
    .windex     (mem_index),
    .wdata      (mem_wdata),
    .wmask      (mem_wmask),
    .load_ena   (load_ena),
    .load_index (load_index),
    .load_data  (load_data)
  );

  commit_tracker i_tracker (
    .clock        (clock),
    .reset        (reset),
    .wb_valid     (wb_valid),
    .wb_pc        (wb_pc),
    .wb_inst      (wb_inst),
    .wb_rd_wena   (wb_rd_wena),
    .wb_rd_index  (wb_rd_index),
    .wb_rd_data   (wb_rd_data),
    .trap_value   (trap_value),
    .commit_valid (commit_valid),
    .commit_skip  (commit_skip),
    .commit_wen   (commit_wen),
    .commit_pc    (commit_pc),
    .commit_inst  (commit_inst),
    .commit_wdest (commit_wdest),
    .commit_wdata (commit_wdata),
    .trap_valid   (trap_valid),
    .trap_code    (trap_code),
    .cycle_count  (cycle_count),
    .instr_count  (instr_count)
  );

endmodule

// ==== verif/sim_top_properties.sv ====
// concurrent assertions on the commit and trap record, bound into sim_top
module sim_top_properties (
  input logic            clock,
  input logic            reset,
  input logic            commit_valid,
  input logic            commit_wen,
  input logic            trap_valid,
  input sim_pkg::count_t cycle_count,
  input sim_pkg::count_t instr_count
);
  timeunit 1ns;
  timeprecision 1ps;

  logic halted;
  // count of failed properties
  int   failures = 0;

  // set by the trap commit, held until the next reset
  always_ff @(posedge clock) begin
    if (reset) begin
      halted <= 1'b0;
    end else if (trap_valid) begin
      halted <= 1'b1;
    end
  end

  wen_needs_valid: assert property (@(posedge clock) disable iff (reset)
    commit_wen |-> commit_valid)
    else begin
      failures++;
      $error("commit_wen high without commit_valid");
    end

  trap_needs_valid: assert property (@(posedge clock) disable iff (reset)
    trap_valid |-> commit_valid)
    else begin
      failures++;
      $error("trap_valid high without commit_valid");
    end

  quiet_after_trap: assert property (@(posedge clock) disable iff (reset)
    halted |-> !commit_valid)
    else begin
      failures++;
      $error("commit after the trap");
    end

  instr_le_cycle: assert property (@(posedge clock) disable iff (reset)
    instr_count <= cycle_count)
    else begin
      failures++;
      $error("instr_count above cycle_count");
    end

endmodule

bind sim_top sim_top_properties i_props (.*);

// ==== verif/tb_sim_top.sv ====
// directed testbench for sim_top; preloads small programs and checks each commit against a model
module tb_sim_top;
  timeunit 1ns;
  timeprecision 1ps;
  import sim_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int MAX_PROG = 32;
  localparam int MARGIN = 12;
  localparam int NUM_TESTS = 5;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * (RESET_CYCLES + MAX_PROG + MARGIN);
  // falling edges from reset release to the first commit, i.e. two rising edges
  localparam int FIRST_COMMIT = 3;
  localparam inst_t TRAP = {25'd0, OPCODE_TRAP};

  logic       clock;
  logic       reset;
  logic       load_ena;
  ram_idx_t   load_index;
  xlen_t      load_data;
  logic       commit_valid;
  logic       commit_skip;
  logic       commit_wen;
  xlen_t      commit_pc;
  inst_t      commit_inst;
  reg_idx_t   commit_wdest;
  xlen_t      commit_wdata;
  logic       trap_valid;
  trap_code_t trap_code;
  count_t     cycle_count;
  count_t     instr_count;

  int          errors;
  int          tests_failed;
  int          total_cycles;
  logic [31:0] seed;
  inst_t       prog[$];
  xlen_t       ref_regs[32];
  xlen_t       ref_mem[int];
  xlen_t       exp_pc[$];
  inst_t       exp_inst[$];
  logic        exp_wen[$];
  reg_idx_t    exp_rd[$];
  xlen_t       exp_data[$];
  trap_code_t  exp_code;

  sim_top i_dut (.*);

  initial clock = 1'b0;
  always #50 clock = ~clock;

  always @(posedge clock) begin
    total_cycles++;
    if (total_cycles > TIMEOUT_CYCLES) begin
      $display("run did not finish within %0d cycles, a program never reached its trap",
               TIMEOUT_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] lcg();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic inst_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [2:0] f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OPCODE_OP};
  endfunction

  function automatic inst_t enc_addi(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, OPCODE_OP_IMM};
  endfunction

  function automatic inst_t enc_ld(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
    return {imm, rs1, 3'b011, rd, OPCODE_LOAD};
  endfunction

  function automatic inst_t enc_sd(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], OPCODE_STORE};
  endfunction

  function automatic xlen_t sext12(logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  // doubleword index as the ISA address map defines it
  function automatic int word_index(xlen_t addr);
    xlen_t off;
    off = (addr - PC_START) >> 3;
    return int'(off[8:0]);
  endfunction

  function automatic xlen_t alu_ref(xlen_t a, xlen_t b, logic [2:0] f3, logic sub);
    case (f3)
      3'b100: return a ^ b;
      3'b110: return a | b;
      3'b111: return a & b;
      default: return sub ? a - b : a + b;
    endcase
  endfunction

  // reference model, the RAM contents carry over between programs like the DUT's
  task automatic build_expected();
    xlen_t pc;
    inst_t inst;
    xlen_t a;
    xlen_t res;
    logic  wen;
    exp_pc.delete();
    exp_inst.delete();
    exp_wen.delete();
    exp_rd.delete();
    exp_data.delete();
    foreach (ref_regs[i]) ref_regs[i] = '0;
    pc = PC_START;
    foreach (prog[i]) begin
      inst = prog[i];
      a = ref_regs[inst[19:15]];
      res = '0;
      wen = 1'b0;
      case (inst[6:0])
        OPCODE_OP: begin
          res = alu_ref(a, ref_regs[inst[24:20]], inst[14:12], inst[30]);
          wen = 1'b1;
        end
        OPCODE_OP_IMM: begin
          res = alu_ref(a, sext12(inst[31:20]), inst[14:12], 1'b0);
          wen = 1'b1;
        end
        OPCODE_LOAD: begin
          res = '0;
          if (ref_mem.exists(word_index(a + sext12(inst[31:20])))) begin
            res = ref_mem[word_index(a + sext12(inst[31:20]))];
          end
          wen = 1'b1;
        end
        OPCODE_STORE: begin
          ref_mem[word_index(a + sext12({inst[31:25], inst[11:7]}))] = ref_regs[inst[24:20]];
        end
        default: begin
          exp_code = ref_regs[10][7:0];
        end
      endcase
      exp_pc.push_back(pc);
      exp_inst.push_back(inst);
      exp_wen.push_back(wen);
      exp_rd.push_back(inst[11:7]);
      exp_data.push_back(res);
      if (wen && (inst[11:7] != 5'd0)) ref_regs[inst[11:7]] = res;
      pc = pc + 64'd4;
    end
  endtask

  task automatic check_xlen(string what, xlen_t got, xlen_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_inst(string what, inst_t got, inst_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_idx(string what, reg_idx_t got, reg_idx_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
    end
  endtask

  task automatic check_code(string what, trap_code_t got, trap_code_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(string what, count_t got, count_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(string what, logic got, logic exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // preload under reset, release, then follow the commit stream to the trap
  task automatic run_program(string name);
    int    start_errors;
    int    k;
    int    cycles;
    logic  done;
    inst_t lo;
    inst_t hi;
    start_errors = errors;
    build_expected();
    for (int i = 0; i < RESET_CYCLES; i++) begin
      lo = (2 * i < prog.size()) ? prog[2 * i] : '0;
      hi = (2 * i + 1 < prog.size()) ? prog[2 * i + 1] : '0;
      @(posedge clock);
      reset      <= 1'b1;
      load_ena   <= (2 * i < prog.size());
      load_index <= ram_idx_t'(i);
      load_data  <= {hi, lo};
    end
    @(negedge clock);
    check_bit("commit_valid in reset", commit_valid, 1'b0);
    check_bit("trap_valid in reset", trap_valid, 1'b0);
    @(posedge clock);
    reset    <= 1'b0;
    load_ena <= 1'b0;
    k = 0;
    cycles = 0;
    done = 1'b0;
    while (!done) begin
      @(negedge clock);
      cycles++;
      // one count per rising edge since reset was released
      check_count("cycle_count", cycle_count, count_t'(cycles - 1));
      if ((k == 0) && !commit_valid) begin
        check_bit("trap_valid before first commit", trap_valid, 1'b0);
      end
      if (commit_valid) begin
        if (k == 0) check_count("first commit latency", count_t'(cycles), FIRST_COMMIT);
        check_bit("commit_skip", commit_skip, k == 0);
        check_xlen("commit_pc", commit_pc, exp_pc[k]);
        check_inst("commit_inst", commit_inst, exp_inst[k]);
        check_bit("commit_wen", commit_wen, exp_wen[k]);
        if (exp_wen[k]) begin
          check_idx("commit_wdest", commit_wdest, exp_rd[k]);
          check_xlen("commit_wdata", commit_wdata, exp_data[k]);
        end
        check_bit("trap_valid", trap_valid, k == prog.size() - 1);
        if (trap_valid) begin
          check_code("trap_code", trap_code, exp_code);
          done = 1'b1;
        end
        k++;
        if (k == prog.size()) done = 1'b1;
      end
    end
    repeat (4) begin
      @(negedge clock);
      check_bit("commit_valid after trap", commit_valid, 1'b0);
    end
    check_count("instr_count", instr_count, count_t'(prog.size()));
    if (errors == start_errors) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: failed", name);
    end
  endtask

  task automatic test_first_commit();
    prog.delete();
    prog.push_back(enc_addi(5'd1, 5'd0, 12'd5));
    prog.push_back(TRAP);
    run_program("reset and first commit");
  endtask

  task automatic test_arith();
    logic [31:0] r;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    prog.delete();
    for (int i = 1; i <= 5; i++) begin
      r = lcg();
      prog.push_back(enc_addi(reg_idx_t'(i), 5'd0, r[19:8]));
    end
    for (int i = 0; i < 20; i++) begin
      r = lcg();
      rd = {1'b0, r[15:12]};
      rs1 = {1'b0, r[19:16]};
      rs2 = {1'b0, r[23:20]};
      case (r[10:8])
        3'd0: prog.push_back(enc_r(7'h00, rs2, rs1, 3'b000, rd));
        3'd1: prog.push_back(enc_r(7'h20, rs2, rs1, 3'b000, rd));
        3'd2: prog.push_back(enc_r(7'h00, rs2, rs1, 3'b100, rd));
        3'd3: prog.push_back(enc_r(7'h00, rs2, rs1, 3'b110, rd));
        3'd4: prog.push_back(enc_r(7'h00, rs2, rs1, 3'b111, rd));
        default: prog.push_back(enc_addi(rd, rs1, r[31:20]));
      endcase
    end
    prog.push_back(TRAP);
    run_program("arithmetic");
  endtask

  // absolute addresses from x0 land in the data area above the program
  task automatic test_memory();
    logic [31:0] r;
    prog.delete();
    r = lcg();
    prog.push_back(enc_addi(5'd1, 5'd0, r[19:8]));
    r = lcg();
    prog.push_back(enc_addi(5'd2, 5'd0, r[19:8]));
    prog.push_back(enc_sd(5'd1, 5'd0, 12'h400));
    prog.push_back(enc_sd(5'd2, 5'd0, 12'h408));
    prog.push_back(enc_ld(5'd3, 5'd0, 12'h400));
    prog.push_back(enc_ld(5'd4, 5'd0, 12'h408));
    prog.push_back(enc_addi(5'd5, 5'd0, 12'h400));
    prog.push_back(enc_ld(5'd6, 5'd5, 12'h008));
    prog.push_back(enc_sd(5'd3, 5'd0, 12'h600));
    prog.push_back(enc_ld(5'd7, 5'd0, 12'h600));
    prog.push_back(TRAP);
    run_program("memory");
  endtask

  task automatic test_x0();
    logic [31:0] r;
    prog.delete();
    r = lcg();
    prog.push_back(enc_addi(5'd1, 5'd0, r[19:8]));
    prog.push_back(enc_addi(5'd0, 5'd0, r[31:20]));
    prog.push_back(enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd0));
    prog.push_back(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd8));
    prog.push_back(enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd9));
    prog.push_back(TRAP);
    run_program("x0 writes");
  endtask

  task automatic test_trap();
    logic [31:0] r;
    prog.delete();
    r = lcg();
    prog.push_back(enc_addi(5'd10, 5'd0, r[19:8]));
    prog.push_back(enc_addi(5'd1, 5'd10, r[31:20]));
    prog.push_back(TRAP);
    run_program("trap");
  endtask

  initial begin
    reset        = 1'b1;
    load_ena     = 1'b0;
    load_index   = '0;
    load_data    = '0;
    errors       = 0;
    tests_failed = 0;
    total_cycles = 0;
    seed         = 32'd4;
    test_first_commit();
    test_arith();
    test_memory();
    test_x0();
    test_trap();
    $display("tests run %0d, failed %0d, mismatches %0d, assertion failures %0d",
             NUM_TESTS, tests_failed, errors, i_dut.i_props.failures);
    if ((errors == 0) && (i_dut.i_props.failures == 0)) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
hdl/sim_pkg.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/rv_core.sv
hdl/ram_helper.sv
hdl/commit_tracker.sv
hdl/sim_top.sv
verif/sim_top_properties.sv
verif/tb_sim_top.sv

// ==== Bender.yml ====
package:
  name: sim_top

sources:
  - hdl/sim_pkg.sv
  - hdl/reg_file.sv
  - hdl/alu.sv
  - hdl/rv_core.sv
  - hdl/ram_helper.sv
  - hdl/commit_tracker.sv
  - hdl/sim_top.sv
  - target: test
    files:
      - verif/sim_top_properties.sv
      - verif/tb_sim_top.sv
